/* softex_cast.f */
+incdir+source
source/softex_cast_pkg.sv
source/softex_stream_intf.sv
source/softex_cast_out.sv
source/softex_stream_fifo.sv
source/softex_cast_cfg.sv
source/softex_cast_top.sv
dv/softex_cast_sva.sv
dv/softex_cast_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the softex cast testbench with Verilator and runs it.
# The exit status is zero only when the run reports a clean result.

set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module softex_cast_tb \
    -f softex_cast.f

# Keep running past assertion failures so the closing counts get printed.
sim_out=$(./obj_dir/Vsoftex_cast_tb +verilator+error+limit+1000)

echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
fi

echo "Simulation did not report a clean result"
exit 1

/* dv/softex_cast_tb.sv */
//##########################################################################
// Softex output cast testbench.
// Random bfloat16 beats through bypass, unsigned and signed casts, with
// back-pressure and configuration changes under traffic.
//##########################################################################

`include "softex_cast_defs.svh"

module softex_cast_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import softex_cast_pkg::*;

    localparam int unsigned CLK_PERIOD   = 8;
    localparam int unsigned RESET_CYCLES = 4;
    localparam int unsigned DRIVE_DELAY  = 1;
    localparam int unsigned BEATS        = 24;
    localparam int unsigned SENDS        = 7;
    localparam int unsigned TIMEOUT_NS   = 20 * BEATS * SENDS * CLK_PERIOD;
    localparam int unsigned LANES        = `SOFTEX_LANES;
    localparam int unsigned FP_W         = `SOFTEX_FP_W;
    localparam int unsigned INT_W        = `SOFTEX_INT_W;
    localparam int          BIAS         = `SOFTEX_BIAS;
    localparam int          MAN_W        = `SOFTEX_MAN_W;
    // Smallest exponent drawn, gives values down to about 2^-15.
    localparam int          EXP_FLOOR    = BIAS - 15;
    // bfloat16 encoding of 1.0.
    localparam logic [15:0] ONE_BF16     = 16'h3f80;

    logic                        clk;
    logic                        rst;
    logic                        cfg_req;
    cast_ctrl_t                  cfg;
    logic                        cfg_ack;
    logic                        in_valid;
    logic                        in_ready;
    logic [`SOFTEX_DATA_W-1:0]   in_data;
    logic [`SOFTEX_DATA_W/8-1:0] in_strb;
    logic                        out_valid;
    logic                        out_ready;
    logic [`SOFTEX_DATA_W-1:0]   out_data;
    logic [`SOFTEX_DATA_W/8-1:0] out_strb;

    logic [31:0]  lfsr_state = 32'h2476b100;
    cast_ctrl_t   model_ctrl = '0;
    logic         ack_prev = 1'b0;
    stream_beat_t expected_q[$];
    string        test_name = "reset";
    int unsigned  errors = 0;
    int unsigned  beats_in = 0;
    int unsigned  beats_out = 0;
    int unsigned  beats_loaded = 0;

    softex_cast_top i_softex_cast_top (
        .clk_i       ( clk       ),
        .rst_i       ( rst       ),
        .cfg_req_i   ( cfg_req   ),
        .cfg_i       ( cfg       ),
        .cfg_ack_o   ( cfg_ack   ),
        .in_valid_i  ( in_valid  ),
        .in_ready_o  ( in_ready  ),
        .in_data_i   ( in_data   ),
        .in_strb_i   ( in_strb   ),
        .out_valid_o ( out_valid ),
        .out_ready_i ( out_ready ),
        .out_data_o  ( out_data  ),
        .out_strb_o  ( out_strb  )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //######################################################################
    // Random source and reference model
    //######################################################################

    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int unsigned k = 0; k < n; k++) begin
            val = {val[30:0], lfsr_step()};
        end
        return val;
    endfunction

    function automatic cast_ctrl_t make_ctrl(input logic en, input logic sgn,
                                             input logic [2:0] int_bits);
        cast_ctrl_t ctrl;
        ctrl.enable    = en;
        ctrl.is_signed = sgn;
        ctrl.int_bits  = int_bits;
        return ctrl;
    endfunction

    // round(value * 2^frac) half up, clipped to the format maximum.
    function automatic logic [7:0] lane_to_fixed(input cast_ctrl_t ctrl,
                                                 input logic [15:0] fp);
        int frac_bits;
        int exp_val;
        int mant;
        int sh;
        int twice;
        int rounded;
        int max_val;
        frac_bits = INT_W - int'(ctrl.is_signed) - int'(ctrl.int_bits);
        max_val   = (1 << (INT_W - int'(ctrl.is_signed))) - 1;
        exp_val   = int'(fp[14:7]);
        mant      = int'({1'b1, fp[6:0]});
        // Twice the scaled value, truncated.
        sh = exp_val - BIAS - MAN_W + frac_bits + 1;
        if (sh > 16) begin
            twice = 2 * max_val + 2;
        end else if (sh >= 0) begin
            twice = mant << sh;
        end else if (sh > -31) begin
            twice = mant >> (-sh);
        end else begin
            twice = 0;
        end
        rounded = (twice + 1) >> 1;
        if (rounded > max_val) begin
            rounded = max_val;
        end
        return 8'(rounded);
    endfunction

    function automatic stream_beat_t expect_beat(input cast_ctrl_t ctrl,
                                                 input logic [`SOFTEX_DATA_W-1:0] data,
                                                 input logic [`SOFTEX_DATA_W/8-1:0] strb);
        stream_beat_t beat;
        beat.data = data;
        beat.strb = strb;
        if (ctrl.enable) begin
            beat = '0;
            for (int lane = 0; lane < LANES; lane++) begin
                beat.data[INT_W*lane +: INT_W] = lane_to_fixed(ctrl, data[FP_W*lane +: FP_W]);
                beat.strb[lane] = strb[2*lane] & strb[2*lane+1];
            end
        end
        return beat;
    endfunction

    //######################################################################
    // Monitor and scoreboard
    //######################################################################

    task automatic check_output();
        stream_beat_t actual;
        stream_beat_t expected;
        actual.data = out_data;
        actual.strb = out_strb;
        beats_out++;
        if (expected_q.size() == 0) begin
            errors++;
            $display("Test %s produced an output beat that was never sent", test_name);
        end else begin
            expected = expected_q.pop_front();
            assert (actual == expected) else begin
                errors++;
                $display("[ERROR] %s: expected data %h strb %h, actual data %h strb %h",
                         test_name, expected.data, expected.strb, actual.data, actual.strb);
            end
        end
    endtask

    // Sampled mid-cycle, so a handshake seen here fires at the next rising edge.
    always @(negedge clk) begin
        if (rst) begin
            ack_prev = 1'b0;
        end else begin
            if (cfg_ack && !ack_prev) begin
                assert (expected_q.size() == 0 && !out_valid) else begin
                    errors++;
                    $display("Test %s saw the configuration taken with beats in flight",
                             test_name);
                end
                model_ctrl = cfg;
            end
            ack_prev = cfg_ack;
            if (in_valid && in_ready) begin
                beats_in++;
                expected_q.push_back(expect_beat(model_ctrl, in_data, in_strb));
            end
            if (out_valid && out_ready) begin
                check_output();
            end
        end
    end

    //######################################################################
    // Drivers
    //######################################################################

    task automatic load_beat();
        logic [7:0] exp_field;
        logic [6:0] man_field;
        for (int lane = 0; lane < LANES; lane++) begin
            exp_field = 8'(EXP_FLOOR) + 8'(rand_bits(4));
            // Keep every lane at or below 1.0.
            man_field = (exp_field == 8'(BIAS)) ? 7'd0 : 7'(rand_bits(7));
            in_data[FP_W*lane +: FP_W] = {1'b0, exp_field, man_field};
        end
        if (beats_loaded % 8 == 0) begin
            in_data[FP_W-1:0] = ONE_BF16;
        end
        in_strb = 8'(rand_bits(8));
        beats_loaded++;
    endtask

    // Entered and left just after a rising edge.
    task automatic send_beats(input int unsigned count, input logic stall);
        int unsigned sent;
        logic        fired;
        sent = 0;
        in_valid = 1'b1;
        load_beat();
        while (sent < count) begin
            out_ready = stall ? lfsr_step() : 1'b1;
            @(negedge clk);
            fired = in_valid && in_ready;
            @(posedge clk);
            #DRIVE_DELAY;
            if (fired) begin
                sent++;
                if (sent < count) begin
                    load_beat();
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
        out_ready = 1'b1;
    endtask

    task automatic wait_drain();
        do begin
            @(negedge clk);
        end while (out_valid);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_config(input cast_ctrl_t ctrl);
        cfg = ctrl;
        cfg_req = 1'b1;
        do begin
            @(negedge clk);
        end while (!cfg_ack);
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_req = 1'b0;
        do begin
            @(negedge clk);
        end while (cfg_ack);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    //######################################################################
    // Test sequence
    //######################################################################

    initial begin
        int unsigned sva_fails;
        rst = 1'b1;
        cfg_req = 1'b0;
        cfg = '0;
        in_valid = 1'b0;
        in_data = '0;
        in_strb = '0;
        out_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_name = "bypass";
        send_beats(BEATS, 1'b0);
        wait_drain();

        test_name = "unsigned_int0";
        load_config(make_ctrl(1'b1, 1'b0, 3'd0));
        send_beats(BEATS, 1'b0);
        wait_drain();

        test_name = "unsigned_int1";
        load_config(make_ctrl(1'b1, 1'b0, 3'd1));
        send_beats(BEATS, 1'b0);
        wait_drain();

        test_name = "signed_int0";
        load_config(make_ctrl(1'b1, 1'b1, 3'd0));
        send_beats(BEATS, 1'b0);
        wait_drain();

        test_name = "backpressure";
        send_beats(BEATS, 1'b1);
        wait_drain();

        // Request a new control while the old one still has beats to cast.
        test_name = "cfg_gating";
        fork
            send_beats(BEATS, 1'b1);
            begin
                repeat (3) @(posedge clk);
                #DRIVE_DELAY;
                load_config(make_ctrl(1'b1, 1'b0, 3'd3));
            end
        join
        wait_drain();

        test_name = "cfg_after";
        send_beats(BEATS, 1'b1);
        wait_drain();

        if (expected_q.size() != 0) begin
            errors++;
            $display("%0d sent beats never reached the output", expected_q.size());
        end
        sva_fails = i_softex_cast_top.i_sva.fail_count;
        $display("Beats in %0d, beats out %0d, check errors %0d, assertion failures %0d",
                 beats_in, beats_out, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with the tests still running", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

/* dv/softex_cast_sva.sv */
//##########################################################################
// Softex cast protocol checker.
// Output stall stability and configuration handshake ordering.
//##########################################################################

`include "softex_cast_defs.svh"

module softex_cast_sva (
    input logic                        clk_i,
    input logic                        rst_i,
    input logic                        cfg_req_i,
    input softex_cast_pkg::cast_ctrl_t cfg_i,
    input logic                        cfg_ack_i,
    input logic                        in_valid_i,
    input logic                        fifo_empty_i,
    input logic                        out_valid_i,
    input logic                        out_ready_i,
    input logic [`SOFTEX_DATA_W-1:0]   out_data_i,
    input logic [`SOFTEX_DATA_W/8-1:0] out_strb_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Read back by the testbench at the end of the run.
    int unsigned fail_count = 0;

    //######################################################################
    // Output stream
    //######################################################################

    out_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_i && !out_ready_i |=>
        out_valid_i && $stable(out_data_i) && $stable(out_strb_i))
    else begin
        fail_count++;
        $error("Output beat changed or dropped while stalled");
    end

    //######################################################################
    // Configuration handshake
    //######################################################################

    ack_low_after_reset: assert property (@(posedge clk_i)
        rst_i |=> !cfg_ack_i)
    else begin
        fail_count++;
        $error("cfg_ack_o high right after reset");
    end

    // Ack may only rise from a request seen with the pipeline empty.
    ack_rise_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !cfg_ack_i && !(cfg_req_i && fifo_empty_i && !in_valid_i) |=> !cfg_ack_i)
    else begin
        fail_count++;
        $error("cfg_ack_o rose while beats were in flight");
    end

    ack_hold_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
        cfg_ack_i && cfg_req_i |=> cfg_ack_i)
    else begin
        fail_count++;
        $error("cfg_ack_o fell before cfg_req_i was released");
    end

    ack_release: assert property (@(posedge clk_i) disable iff (rst_i)
        cfg_ack_i && !cfg_req_i |=> !cfg_ack_i)
    else begin
        fail_count++;
        $error("cfg_ack_o stayed high after cfg_req_i fell");
    end

    req_hold_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        cfg_req_i && !cfg_ack_i |=> cfg_req_i && $stable(cfg_i))
    else begin
        fail_count++;
        $error("cfg_req_i or cfg_i changed before cfg_ack_o");
    end

endmodule

bind softex_cast_top softex_cast_sva i_sva (
    .clk_i        ( clk_i       ),
    .rst_i        ( rst_i       ),
    .cfg_req_i    ( cfg_req_i   ),
    .cfg_i        ( cfg_i       ),
    .cfg_ack_i    ( cfg_ack_o   ),
    .in_valid_i   ( in_valid_i  ),
    .fifo_empty_i ( fifo_empty  ),
    .out_valid_i  ( out_valid_o ),
    .out_ready_i  ( out_ready_i ),
    .out_data_i   ( out_data_o  ),
    .out_strb_i   ( out_strb_o  )
);

/* source/softex_cast_top.sv */
//##########################################################################
// Softex output cast stage.
// Configuration register, lane cast and output FIFO behind plain ports.
//##########################################################################

`include "softex_cast_defs.svh"

module softex_cast_top (
    input  logic                        clk_i,
    input  logic                        rst_i,

    // Configuration handshake.
    input  logic                        cfg_req_i,
    input  softex_cast_pkg::cast_ctrl_t cfg_i,
    output logic                        cfg_ack_o,

    // Input stream.
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  logic [`SOFTEX_DATA_W-1:0]   in_data_i,
    input  logic [`SOFTEX_DATA_W/8-1:0] in_strb_i,

    // Output stream.
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [`SOFTEX_DATA_W-1:0]   out_data_o,
    output logic [`SOFTEX_DATA_W/8-1:0] out_strb_o
);

    import softex_cast_pkg::*;

    cast_ctrl_t   ctrl;
    stream_beat_t pop_beat;
    logic         fifo_empty;
    logic         idle;

    softex_stream_intf in_s ();
    softex_stream_intf cast_s ();

    // Bundle the plain input ports.
    assign in_s.valid = in_valid_i;
    assign in_s.data  = in_data_i;
    assign in_s.strb  = in_strb_i;
    assign in_ready_o = in_s.ready;

    // Nothing stored and nothing offered.
    assign idle = fifo_empty & ~in_valid_i;

    softex_cast_cfg i_cfg (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .cfg_req_i ( cfg_req_i ),
        .cfg_i     ( cfg_i     ),
        .idle_i    ( idle      ),
        .cfg_ack_o ( cfg_ack_o ),
        .ctrl_o    ( ctrl      )
    );

    softex_cast_out i_cast_out (
        .ctrl_i   ( ctrl   ),
        .stream_i ( in_s   ),
        .stream_o ( cast_s )
    );

    softex_stream_fifo #(
        .T_BEAT ( stream_beat_t      ),
        .DEPTH  ( `SOFTEX_FIFO_DEPTH )
    ) i_out_fifo (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .push_s      ( cast_s      ),
        .pop_valid_o ( out_valid_o ),
        .pop_ready_i ( out_ready_i ),
        .pop_beat_o  ( pop_beat    ),
        .empty_o     ( fifo_empty  )
    );

    assign out_data_o = pop_beat.data;
    assign out_strb_o = pop_beat.strb;

endmodule

/* source/softex_cast_cfg.sv */
//##########################################################################
// Softex cast configuration.
// Control register loaded by a four-phase req/ack handshake, accepted
// only while the pipeline holds no beat.
//##########################################################################

module softex_cast_cfg (
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  logic                        cfg_req_i,
    input  softex_cast_pkg::cast_ctrl_t cfg_i,
    input  logic                        idle_i,
    output logic                        cfg_ack_o,

    output softex_cast_pkg::cast_ctrl_t ctrl_o
);

    typedef enum logic {
        CFG_WAIT,
        CFG_ACK
    } cfg_state_e;

    cfg_state_e state_q;

    assign cfg_ack_o = (state_q == CFG_ACK);

    //######################################################################
    // Handshake FSM
    //######################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= CFG_WAIT;
            ctrl_o  <= '0;
        end else begin
            case (state_q)
                CFG_WAIT: begin
                    // Hold off until no beat is in flight.
                    if (cfg_req_i && idle_i) begin
                        ctrl_o  <= cfg_i;
                        state_q <= CFG_ACK;
                    end
                end
                CFG_ACK: begin
                    if (!cfg_req_i) begin
                        state_q <= CFG_WAIT;
                    end
                end
                default: state_q <= CFG_WAIT;
            endcase
        end
    end

endmodule

/* source/softex_stream_fifo.sv */
//##########################################################################
// Softex stream FIFO.
// Circular buffer of beats with valid/ready on both sides.
//##########################################################################

`include "softex_cast_defs.svh"

module softex_stream_fifo #(
    parameter type         T_BEAT = softex_cast_pkg::stream_beat_t,
    parameter int unsigned DEPTH  = `SOFTEX_FIFO_DEPTH
) (
    input  logic            clk_i,
    input  logic            rst_i,

    softex_stream_intf.sink push_s,

    output logic            pop_valid_o,
    input  logic            pop_ready_i,
    output T_BEAT           pop_beat_o,
    output logic            empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    T_BEAT            mem [DEPTH];
    T_BEAT            push_beat;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push_beat = {push_s.data, push_s.strb};

    assign push_s.ready = (count != CNT_W'(DEPTH));
    assign pop_valid_o  = (count != '0);
    assign empty_o      = (count == '0);
    assign pop_beat_o   = mem[rd_ptr];

    assign push = push_s.valid & push_s.ready;
    assign pop  = pop_valid_o & pop_ready_i;

    //######################################################################
    // Storage
    //######################################################################

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    //######################################################################
    // Pointers and occupancy
    //######################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            // Simultaneous push and pop leave the count as is.
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/softex_cast_out.sv */
//##########################################################################
// Softex output cast.
// Converts each bfloat16 lane in [0, 1] to 8-bit fixed point, rounding
// half up and saturating, with strobe remapping. Bypass when disabled.
//##########################################################################

`include "softex_cast_defs.svh"

module softex_cast_out (
    input  softex_cast_pkg::cast_ctrl_t ctrl_i,

    softex_stream_intf.sink             stream_i,
    softex_stream_intf.source           stream_o
);

    localparam int unsigned DATA_W  = `SOFTEX_DATA_W;
    localparam int unsigned STRB_W  = DATA_W / 8;
    localparam int unsigned INT_W   = `SOFTEX_INT_W;
    localparam int unsigned FP_W    = `SOFTEX_FP_W;
    localparam int unsigned EXP_W   = `SOFTEX_EXP_W;
    localparam int unsigned MAN_W   = `SOFTEX_MAN_W;
    localparam int unsigned BIAS    = `SOFTEX_BIAS;
    localparam int unsigned LANES   = `SOFTEX_LANES;

    // Aligned mantissa plus one round bit below the result.
    localparam int unsigned SHIFT_W = (MAN_W > INT_W) ? MAN_W + 1 : INT_W + 1;
    localparam int unsigned PAD_W   = SHIFT_W - MAN_W - 1;
    localparam int unsigned SHAMT_W = EXP_W + 1;

    localparam logic [INT_W-1:0] UNSIGNED_MAX = '1;
    localparam logic [INT_W-1:0] SIGNED_MAX   = {1'b0, {(INT_W-1){1'b1}}};

    logic [LANES-1:0][FP_W-1:0]      lanes_in;
    logic [LANES-1:0][EXP_W-1:0]     exps;
    logic [LANES-1:0][MAN_W-1:0]     mans;
    logic [LANES-1:0]                exp_ovf;
    logic [LANES-1:0]                sat;
    logic [LANES-1:0][SHAMT_W-1:0]   shamt;
    logic [LANES-1:0][SHIFT_W-1:0]   shifted;
    logic [LANES-1:0][INT_W:0]       rounded;
    logic [LANES-1:0][INT_W-1:0]     results;
    logic [LANES-1:0][INT_W/8-1:0]   strbs;

    assign lanes_in = stream_i.data;

    //######################################################################
    // Per-lane conversion
    //######################################################################

    for (genvar i = 0; i < LANES; i++) begin : gen_lane
        assign exps[i] = lanes_in[i][FP_W-2 -: EXP_W];
        assign mans[i] = lanes_in[i][MAN_W-1:0];

        // Value reaches the first weight above the integer range.
        assign exp_ovf[i] = (SHAMT_W'(exps[i]) + SHAMT_W'(1)) >
                            (SHAMT_W'(BIAS) + SHAMT_W'(ctrl_i.is_signed) +
                             SHAMT_W'(ctrl_i.int_bits));

        // Only meaningful when the lane does not overflow.
        assign shamt[i] = SHAMT_W'(BIAS) + SHAMT_W'(ctrl_i.is_signed) +
                          SHAMT_W'(ctrl_i.int_bits) - SHAMT_W'(exps[i]) -
                          SHAMT_W'(1);

        assign shifted[i] = {1'b1, mans[i], {PAD_W{1'b0}}} >> shamt[i];

        // Round half up on the first dropped bit.
        assign rounded[i] = {1'b0, shifted[i][SHIFT_W-1 -: INT_W]} +
                            {{INT_W{1'b0}}, shifted[i][SHIFT_W-INT_W-1]};

        // Rounding may still carry into the sign bit.
        assign sat[i] = exp_ovf[i] | rounded[i][INT_W] |
                        (ctrl_i.is_signed & rounded[i][INT_W-1]);

        assign results[i] = !sat[i]          ? rounded[i][INT_W-1:0] :
                            ctrl_i.is_signed ? SIGNED_MAX : UNSIGNED_MAX;

        // Result byte is valid only if both source bytes are.
        assign strbs[i] = {(INT_W/8){&stream_i.strb[i*FP_W/8 +: FP_W/8]}};
    end

    //######################################################################
    // Stream outputs
    //######################################################################

    assign stream_i.ready = stream_o.ready;
    assign stream_o.valid = stream_i.valid;

    // Results pack into the low bits, the rest reads as zero.
    assign stream_o.data = ctrl_i.enable ?
                           {{(DATA_W-LANES*INT_W){1'b0}}, results} :
                           stream_i.data;
    assign stream_o.strb = ctrl_i.enable ?
                           {{(STRB_W-LANES*INT_W/8){1'b0}}, strbs} :
                           stream_i.strb;

endmodule

/* source/softex_stream_intf.sv */
//##########################################################################
// Softex stream interface.
// Valid/ready bundle with a data word and a byte strobe.
//##########################################################################

`include "softex_cast_defs.svh"

interface softex_stream_intf;

    logic                        valid;
    logic                        ready;
    logic [`SOFTEX_DATA_W-1:0]   data;
    logic [`SOFTEX_DATA_W/8-1:0] strb;

    // Producer side holds valid, data and strb until ready.
    modport source (
        output valid, data, strb,
        input  ready
    );

    modport sink (
        input  valid, data, strb,
        output ready
    );

    // Passive observer, e.g. for checkers.
    modport monitor (
        input valid, ready, data, strb
    );

endinterface

/* source/softex_cast_pkg.sv */
//##########################################################################
// Softex output cast package.
// Control word and stream beat types shared across the cast stage.
//##########################################################################

`include "softex_cast_defs.svh"

package softex_cast_pkg;

    //######################################################################
    // Cast control
    //######################################################################

    // Loaded through the configuration handshake.
    // All zeros selects bypass.
    typedef struct packed {
        // Cast when set, pass beats through otherwise.
        logic       enable;
        // Result carries a sign bit.
        logic       is_signed;
        // Integer bits of the result, sign bit not counted.
        logic [2:0] int_bits;
    } cast_ctrl_t;

    //######################################################################
    // Stream beat
    //######################################################################

    // One valid/ready transfer, as held by the output FIFO.
    typedef struct packed {
        logic [`SOFTEX_DATA_W-1:0]   data;
        logic [`SOFTEX_DATA_W/8-1:0] strb;
    } stream_beat_t;

endpackage

/* source/softex_cast_defs.svh */
//##########################################################################
// Softex output cast defines.
// Stream geometry, bfloat16 field layout and output FIFO sizing.
//##########################################################################

`ifndef SOFTEX_CAST_DEFS_SVH
`define SOFTEX_CAST_DEFS_SVH

// Stream data width in bits. The strobe has one bit per byte.
`define SOFTEX_DATA_W 64

// Width of one cast result.
`define SOFTEX_INT_W 8

// bfloat16 layout.
`define SOFTEX_FP_W 16
`define SOFTEX_EXP_W 8
`define SOFTEX_MAN_W 7
`define SOFTEX_BIAS 127

// Floating-point lanes per beat.
`define SOFTEX_LANES (`SOFTEX_DATA_W / `SOFTEX_FP_W)

// Output FIFO entries.
`define SOFTEX_FIFO_DEPTH 4

`endif
